// File: hdl/dCachePkg.sv
package dCachePkg;

	// geometry
	localparam int addrWidth = 32;
	localparam int wordWidth = 32;
	localparam int offsetBits = 6;
	localparam int indexBits = 4;
	localparam int tagBits = addrWidth - indexBits - offsetBits;
	localparam int numSets = 1 << indexBits;
	localparam int wordsPerLine = (1 << offsetBits) / (wordWidth / 8);

	typedef logic [addrWidth-1:0] addr_t;
	typedef logic [wordWidth-1:0] word_t;
	typedef logic [tagBits-1:0] tag_t;
	typedef logic [indexBits-1:0] index_t;
	typedef logic [wordsPerLine*wordWidth-1:0] line_t; // word 0 in the low bits
	typedef logic [addrWidth-offsetBits-1:0] blockAddr_t;

	typedef enum logic {
		opRead,
		opWrite
	} cacheOp_t;

	// codes kept from the older cache
	typedef enum logic [1:0] {
		statusNone = 2'd0,
		statusWaiting = 2'd1,
		statusHit = 2'd2,
		statusMiss = 2'd3
	} cacheStatus_t;

	typedef enum logic [1:0] {
		stIdle,
		stWriteBack,
		stRefill
	} missState_t;

	typedef struct packed {
		cacheOp_t op;
		addr_t addr;
		word_t writeData;
	} cpuReq_t;

	typedef struct packed {
		blockAddr_t blockAddr;
		line_t line;
	} memReq_t;

endpackage

// File: hdl/cacheStore.sv
module cacheStore (
	input logic clk,
	input logic reset,
	input dCachePkg::cpuReq_t cpuReq,
	input logic touch,
	input logic captureVictim,
	input logic fill,
	input dCachePkg::line_t fillLine,
	input logic invalStrobe,
	input dCachePkg::addr_t invalAddr,
	output logic hit,
	output dCachePkg::word_t readData,
	output logic victimDirty,
	output dCachePkg::memReq_t victim,
	output dCachePkg::blockAddr_t refillAddr
);
	import dCachePkg::*;

	tag_t tagArr [2][numSets];
	line_t dataArr [2][numSets];
	logic [1:0][numSets-1:0] valid;
	logic [1:0][numSets-1:0] dirty;
	logic [numSets-1:0] lru; // way to replace next, per set

	logic fillWay; // latched at the miss edge

	index_t reqIndex;
	tag_t reqTag;
	logic [$clog2(wordsPerLine)-1:0] wordSel;
	logic [1:0] wayHit;
	logic hitWay;
	logic victimWay;

	index_t invalIndex;
	tag_t invalTag;
	logic [1:0] invalMatch;

	assign reqIndex = cpuReq.addr[offsetBits +: indexBits];
	assign reqTag = cpuReq.addr[addrWidth-1 -: tagBits];
	assign wordSel = cpuReq.addr[offsetBits-1 -: $clog2(wordsPerLine)]; // bits 5:2

	assign invalIndex = invalAddr[offsetBits +: indexBits];
	assign invalTag = invalAddr[addrWidth-1 -: tagBits];

	// tag compare on both ways, for the cpu and the snoop address
	always_comb begin
		for (int w = 0; w < 2; w++) begin
			wayHit[w] = valid[w][reqIndex] && (tagArr[w][reqIndex] == reqTag);
			invalMatch[w] = valid[w][invalIndex] && (tagArr[w][invalIndex] == invalTag);
		end
	end

	assign hit = |wayHit;
	assign hitWay = wayHit[1]; // both ways never hold the same tag

	assign readData = dataArr[hitWay][reqIndex][wordSel*wordWidth +: wordWidth];

	// invalid way first, way 0 before way 1, else lru
	always_comb begin
		if (!valid[0][reqIndex]) begin
			victimWay = 1'b0;
		end else if (!valid[1][reqIndex]) begin
			victimWay = 1'b1;
		end else begin
			victimWay = lru[reqIndex];
		end
	end

	assign victimDirty = valid[victimWay][reqIndex] && dirty[victimWay][reqIndex];

	// write-back image of the latched way, request held by the cpu
	assign victim.blockAddr = {tagArr[fillWay][reqIndex], reqIndex};
	assign victim.line = dataArr[fillWay][reqIndex];

	assign refillAddr = cpuReq.addr[addrWidth-1:offsetBits];

	// tag and data arrays
	always_ff @(posedge clk) begin
		if (touch && (cpuReq.op == opWrite)) begin
			dataArr[hitWay][reqIndex][wordSel*wordWidth +: wordWidth] <= cpuReq.writeData;
		end
		if (fill) begin
			dataArr[fillWay][reqIndex] <= fillLine;
			tagArr[fillWay][reqIndex] <= reqTag;
		end
		if (captureVictim) begin
			fillWay <= victimWay;
		end
	end

	// valid, dirty and lru state
	always_ff @(posedge clk) begin
		if (reset) begin
			valid <= '0;
			dirty <= '0;
			lru <= '0;
		end else begin
			if (invalStrobe) begin
				for (int w = 0; w < 2; w++) begin
					if (invalMatch[w]) begin
						valid[w][invalIndex] <= 1'b0; // dirty data is dropped
					end
				end
			end

			if (touch) begin
				lru[reqIndex] <= ~hitWay;
				if (cpuReq.op == opWrite) begin
					dirty[hitWay][reqIndex] <= 1'b1;
				end
			end

			// a fill in the same set as a snoop still lands, since it comes last
			if (fill) begin
				valid[fillWay][reqIndex] <= 1'b1;
				dirty[fillWay][reqIndex] <= 1'b0;
				lru[reqIndex] <= ~fillWay;
			end
		end
	end

endmodule

// File: hdl/missControl.sv
module missControl (
	input logic clk,
	input logic reset,
	input logic enable,
	input dCachePkg::cacheOp_t op,
	input logic hit,
	input logic victimDirty,
	input logic invalStrobe,
	input logic refillDone,
	input logic wbDone,
	output dCachePkg::cacheStatus_t status,
	output logic touch,
	output logic captureVictim,
	output logic fill,
	output logic refillReq,
	output logic wbReq
);
	import dCachePkg::*;

	missState_t state;
	missState_t stateNext;
	logic issue; // one cycle after entering a memory state
	logic accept;

	// the cpu request may act on the store this cycle
	assign accept = enable && (state == stIdle) && !invalStrobe;

	assign touch = accept && hit; // lru on every hit, word and dirty bit when op is a write
	assign captureVictim = accept && !hit;
	assign fill = refillDone && (state == stRefill);

	assign wbReq = issue && (state == stWriteBack);
	assign refillReq = issue && (state == stRefill);

	always_comb begin
		if (!enable || invalStrobe) begin
			status = statusNone;
		end else if (state != stIdle) begin
			status = statusWaiting;
		end else if (hit) begin
			status = statusHit;
		end else begin
			status = statusMiss;
		end
	end

	always_comb begin
		stateNext = state;
		unique case (state)
			stIdle: begin
				if (captureVictim) begin
					stateNext = victimDirty ? stWriteBack : stRefill;
				end
			end
			stWriteBack: begin
				if (wbDone) begin
					stateNext = stRefill;
				end
			end
			stRefill: begin
				if (refillDone) begin
					stateNext = stIdle; // held request hits next cycle
				end
			end
			default: stateNext = stIdle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= stIdle;
			issue <= 1'b0;
		end else begin
			state <= stateNext;
			issue <= (stateNext != state) && (stateNext != stIdle);
		end
	end

endmodule

// File: hdl/dCache.sv
module dCache (
	input logic clk,
	input logic reset,
	input logic enable,
	input dCachePkg::cpuReq_t cpuReq,
	output dCachePkg::cacheStatus_t status,
	output dCachePkg::word_t readData,
	output logic refillReq,
	output dCachePkg::blockAddr_t refillAddr,
	input logic refillDone,
	input dCachePkg::line_t refillLine,
	output logic wbReq,
	output dCachePkg::memReq_t wb,
	input logic wbDone,
	input logic invalStrobe,
	input dCachePkg::addr_t invalAddr
);

	logic hit;
	logic victimDirty;
	logic touch;
	logic captureVictim;
	logic fill;

	cacheStore store (
		.clk(clk),
		.reset(reset),
		.cpuReq(cpuReq),
		.touch(touch),
		.captureVictim(captureVictim),
		.fill(fill),
		.fillLine(refillLine),
		.invalStrobe(invalStrobe),
		.invalAddr(invalAddr),
		.hit(hit),
		.readData(readData),
		.victimDirty(victimDirty),
		.victim(wb),
		.refillAddr(refillAddr)
	);

	missControl ctrl (
		.clk(clk),
		.reset(reset),
		.enable(enable),
		.op(cpuReq.op),
		.hit(hit),
		.victimDirty(victimDirty),
		.invalStrobe(invalStrobe),
		.refillDone(refillDone),
		.wbDone(wbDone),
		.status(status),
		.touch(touch),
		.captureVictim(captureVictim),
		.fill(fill),
		.refillReq(refillReq),
		.wbReq(wbReq)
	);

endmodule

// File: sim/dCache_sva.sv
module dCacheSva (
	input logic clk,
	input logic reset,
	input dCachePkg::cacheStatus_t status,
	input dCachePkg::missState_t state,
	input logic refillReq,
	input logic refillDone,
	input logic wbReq,
	input logic wbDone
);
	import dCachePkg::*;

	int failCount = 0;
	logic refillOpen; // issued, not yet answered
	logic wbOpen;

	always_ff @(posedge clk) begin
		if (reset) begin
			refillOpen <= 1'b0;
			wbOpen <= 1'b0;
		end else begin
			if (refillReq) begin
				refillOpen <= 1'b1;
			end else if (refillDone) begin
				refillOpen <= 1'b0;
			end
			if (wbReq) begin
				wbOpen <= 1'b1;
			end else if (wbDone) begin
				wbOpen <= 1'b0;
			end
		end
	end

	singleRefill: assert property (@(posedge clk) disable iff (reset) refillReq |=> !refillReq)
		else begin
			failCount++;
			$error("refillReq held for more than one cycle");
		end

	singleWb: assert property (@(posedge clk) disable iff (reset) wbReq |=> !wbReq)
		else begin
			failCount++;
			$error("wbReq held for more than one cycle");
		end

	// one memory request at a time
	noOverlap: assert property (@(posedge clk) disable iff (reset)
		(refillReq || wbReq) |-> !(refillOpen || wbOpen))
		else begin
			failCount++;
			$error("memory request issued while another is outstanding");
		end

	hitIdle: assert property (@(posedge clk) disable iff (reset)
		(status == statusHit) |-> !(refillOpen || wbOpen))
		else begin
			failCount++;
			$error("hit reported while a memory request is outstanding");
		end

	// controller stays busy until memory answers
	openBusy: assert property (@(posedge clk) disable iff (reset)
		(refillOpen || wbOpen) |-> (state != stIdle))
		else begin
			failCount++;
			$error("miss controller idle while a memory request is outstanding");
		end

endmodule

// File: sim/dCacheTb.sv
module dCacheTb;
	import dCachePkg::*;

	localparam int numOps = 2000;
	localparam int cycleLimit = numOps * 40;

	logic clk = 1'b0;
	logic reset;
	logic enable;
	cpuReq_t cpuReq;
	cacheStatus_t status;
	word_t readData;
	logic refillReq;
	blockAddr_t refillAddr;
	logic refillDone;
	line_t refillLine;
	logic wbReq;
	memReq_t wb;
	logic wbDone;
	logic invalStrobe;
	addr_t invalAddr;

	// reference cache
	tag_t mTag [2][numSets];
	line_t mData [2][numSets];
	logic mValid [2][numSets];
	logic mDirty [2][numSets];
	logic mLru [numSets]; // way to replace next
	word_t mem [logic [29:0]]; // written words only, keyed by word address
	int cycles = 0;

	dCache dut (.*);

	bind dCache dCacheSva sva (
		.clk(clk),
		.reset(reset),
		.status(status),
		.state(ctrl.state),
		.refillReq(refillReq),
		.refillDone(refillDone),
		.wbReq(wbReq),
		.wbDone(wbDone)
	);

	always #10 clk = ~clk;

	always @(posedge clk) begin
		cycles++;
		if (cycles >= cycleLimit) begin
			stopOnError("timeout: the run did not finish within the cycle limit");
		end
	end

	always @(negedge clk) begin
		if (dut.sva.failCount != 0) begin
			stopOnError("a protocol assertion on the memory port or status failed");
		end
	end

	task automatic stopOnError(input string msg);
		$display("%s", msg);
		$display("TEST FAILED");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic checkStatus(input cacheStatus_t got, input cacheStatus_t exp, input string what);
		if (got !== exp) begin
			stopOnError($sformatf("FAIL %0t: %s status %0d expected %0d", $time, what, got, exp));
		end
	endtask

	task automatic checkWord(input word_t got, input word_t exp, input string what);
		if (got !== exp) begin
			stopOnError($sformatf("FAIL %0t: %s got %h expected %h", $time, what, got, exp));
		end
	endtask

	task automatic checkBlockAddr(input blockAddr_t got, input blockAddr_t exp, input string what);
		if (got !== exp) begin
			stopOnError($sformatf("FAIL %0t: %s got %h expected %h", $time, what, got, exp));
		end
	endtask

	task automatic checkLine(input line_t got, input line_t exp, input string what);
		if (got !== exp) begin
			stopOnError($sformatf("FAIL %0t: %s got %h expected %h", $time, what, got, exp));
		end
	endtask

	// contents of a word never written, spread over the whole address
	function automatic word_t initWord(input logic [29:0] wordAddr);
		logic [31:0] a;
		a = {2'b00, wordAddr};
		return (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]};
	endfunction

	function automatic line_t memLine(input blockAddr_t b);
		line_t l;
		for (int i = 0; i < wordsPerLine; i++) begin
			if (mem.exists({b, 4'(i)})) begin
				l[i*wordWidth +: wordWidth] = mem[{b, 4'(i)}];
			end else begin
				l[i*wordWidth +: wordWidth] = initWord({b, 4'(i)});
			end
		end
		return l;
	endfunction

	task automatic storeLine(input blockAddr_t b, input line_t l);
		for (int i = 0; i < wordsPerLine; i++) begin
			mem[{b, 4'(i)}] = l[i*wordWidth +: wordWidth];
		end
	endtask

	// 4 tags per set keeps both ways under pressure
	function automatic addr_t randomAddr();
		tag_t tg;
		tg = tag_t'($urandom_range(3, 0) * 32'h0001_3a7 + 32'h0000_0c5);
		return {tg, index_t'($urandom_range(15, 0)), 4'($urandom_range(15, 0)), 2'b00};
	endfunction

	function automatic int findWay(input index_t idx, input tag_t tg);
		for (int w = 0; w < 2; w++) begin
			if (mValid[w][idx] && (mTag[w][idx] == tg)) begin
				return w;
			end
		end
		return -1;
	endfunction

	function automatic int victimOf(input index_t idx);
		if (!mValid[0][idx]) begin
			return 0;
		end else if (!mValid[1][idx]) begin
			return 1;
		end
		return mLru[idx] ? 1 : 0;
	endfunction

	task automatic step();
		@(posedge clk);
		#2;
		invalStrobe = 1'b0;
		refillDone = 1'b0;
		wbDone = 1'b0;
	endtask

	task automatic checkQuiet();
		if (wbReq || refillReq) begin
			stopOnError("memory request issued while no miss was pending");
		end
	endtask

	task automatic waitRequest(input logic wantRefill);
		for (int n = 0; n < 8; n++) begin
			step();
			@(negedge clk);
			checkStatus(status, statusWaiting, "miss wait");
			if (wantRefill ? wbReq : refillReq) begin
				stopOnError("the wrong kind of memory request was issued");
			end
			if (wantRefill ? refillReq : wbReq) begin
				return;
			end
		end
		stopOnError("the expected memory request was never issued");
	endtask

	// memory answers after 1 to 8 cycles
	task automatic respond(input logic wantRefill, input blockAddr_t b);
		int d;
		d = $urandom_range(8, 1);
		for (int i = 0; i < d; i++) begin
			step();
			if (i == d - 1) begin
				if (wantRefill) begin
					refillDone = 1'b1;
					refillLine = memLine(b);
				end else begin
					wbDone = 1'b1;
				end
			end
			@(negedge clk);
			checkStatus(status, statusWaiting, "memory wait");
			checkQuiet();
		end
	endtask

	task automatic access(input cpuReq_t req);
		index_t idx;
		tag_t tg;
		logic [3:0] sel;
		int way;
		blockAddr_t victimAddr;
		idx = req.addr[offsetBits +: indexBits];
		tg = req.addr[addrWidth-1 -: tagBits];
		sel = req.addr[5:2];
		enable = 1'b1;
		cpuReq = req;
		@(negedge clk);
		way = findWay(idx, tg);
		if (way < 0) begin
			checkStatus(status, statusMiss, "lookup");
			checkQuiet();
			way = victimOf(idx);
			if (mValid[way][idx] && mDirty[way][idx]) begin
				victimAddr = {mTag[way][idx], idx};
				waitRequest(1'b0);
				checkBlockAddr(wb.blockAddr, victimAddr, "write-back address");
				checkLine(wb.line, mData[way][idx], "write-back line");
				storeLine(victimAddr, mData[way][idx]);
				respond(1'b0, victimAddr);
			end
			waitRequest(1'b1);
			checkBlockAddr(refillAddr, req.addr[addrWidth-1:offsetBits], "refill address");
			respond(1'b1, req.addr[addrWidth-1:offsetBits]);
			mTag[way][idx] = tg;
			mData[way][idx] = memLine(req.addr[addrWidth-1:offsetBits]);
			mValid[way][idx] = 1'b1;
			mDirty[way][idx] = 1'b0;
			mLru[idx] = (way == 0);
			step();
			@(negedge clk);
		end
		checkStatus(status, statusHit, "access");
		checkQuiet();
		if (req.op == opRead) begin
			checkWord(readData, mData[way][idx][sel*wordWidth +: wordWidth], "read data");
		end else begin
			mData[way][idx][sel*wordWidth +: wordWidth] = req.writeData;
			mDirty[way][idx] = 1'b1;
		end
		mLru[idx] = (way == 0);
	endtask

	task automatic snoop(input addr_t a);
		index_t idx;
		tag_t tg;
		idx = a[offsetBits +: indexBits];
		tg = a[addrWidth-1 -: tagBits];
		invalStrobe = 1'b1;
		invalAddr = a;
		enable = 1'($urandom_range(1, 0));
		@(negedge clk);
		checkStatus(status, statusNone, "snoop cycle");
		checkQuiet();
		for (int w = 0; w < 2; w++) begin
			if (mValid[w][idx] && (mTag[w][idx] == tg)) begin
				mValid[w][idx] = 1'b0; // dirty data is lost
			end
		end
	endtask

	initial begin
		cpuReq_t req;
		void'($urandom(32'h5807_1c0e));
		reset = 1'b1;
		enable = 1'b0;
		cpuReq = '0;
		refillDone = 1'b0;
		refillLine = '0;
		wbDone = 1'b0;
		invalStrobe = 1'b0;
		invalAddr = '0;
		for (int s = 0; s < numSets; s++) begin
			mValid[0][s] = 1'b0;
			mValid[1][s] = 1'b0;
			mDirty[0][s] = 1'b0;
			mDirty[1][s] = 1'b0;
			mLru[s] = 1'b0;
		end
		repeat (3) @(posedge clk);
		#2;
		reset = 1'b0;
		@(negedge clk);
		checkStatus(status, statusNone, "after reset");
		checkQuiet();

		for (int n = 0; n < numOps; n++) begin
			step();
			if ($urandom_range(7, 0) == 0) begin
				snoop(randomAddr());
				step();
			end
			req.op = ($urandom_range(9, 0) < 4) ? opWrite : opRead;
			req.addr = randomAddr();
			req.writeData = $urandom();
			access(req);
		end
		step();
		enable = 1'b0;
		@(negedge clk);

		$display("TEST OK");
		$finish;
	end

endmodule

// File: compile.f
hdl/dCachePkg.sv
hdl/cacheStore.sv
hdl/missControl.sv
hdl/dCache.sv
sim/dCache_sva.sv
sim/dCacheTb.sv

// File: Bender.yml
package:
  name: dcache

sources:
  - hdl/dCachePkg.sv
  - hdl/cacheStore.sv
  - hdl/missControl.sv
  - hdl/dCache.sv
  - target: simulation
    files:
      - sim/dCache_sva.sv
      - sim/dCacheTb.sv
